// File: logic/hpdcache_defs.svh
/*
 * Sizing macros for the cache. Addresses count words, not bytes.
 * HPDCACHE_SETS and HPDCACHE_NREQ must be powers of two.
 */
`ifndef HPDCACHE_DEFS_SVH
`define HPDCACHE_DEFS_SVH

// Word address and data widths
`define HPDCACHE_ADDR_W 16
`define HPDCACHE_DATA_W 32

// One word per line, direct mapped
`define HPDCACHE_SETS 16

`define HPDCACHE_NREQ 2
`define HPDCACHE_WBUF_DEPTH 4

`endif

// File: logic/hpdcache_pkg.sv
/*
 * Shared address, data and id types for the cache.
 * Widths follow the macros in the defs header.
 */
`default_nettype none

package hpdcache_pkg;

`include "hpdcache_defs.svh"

    typedef logic [`HPDCACHE_ADDR_W-1:0] addr_t;
    typedef logic [`HPDCACHE_DATA_W-1:0] word_t;

    // Low address bits select the line
    typedef logic [$clog2(`HPDCACHE_SETS)-1:0] set_t;

    // Remaining high bits are kept as tag
    typedef logic [`HPDCACHE_ADDR_W-$clog2(`HPDCACHE_SETS)-1:0] tag_t;

    typedef logic [$clog2(`HPDCACHE_NREQ)-1:0] sid_t;

endpackage

`default_nettype wire

// File: logic/hpdcache_ifs.sv
/*
 * Internal channels between arbiter, controller, miss handler and write buffer.
 * All transfers complete on valid and ready high, except the refill pulse.
 */
`timescale 1ns/1ns
`default_nettype none

interface hpdcache_req_if;
    logic                valid;
    logic                ready;
    logic                we;
    hpdcache_pkg::addr_t addr;
    hpdcache_pkg::word_t wdata;
    hpdcache_pkg::sid_t  sid;

    modport arbiter (output valid, we, addr, wdata, sid, input ready);
    modport ctrl    (input valid, we, addr, wdata, sid, output ready);
endinterface

interface hpdcache_miss_if;
    logic                req_valid;
    logic                req_ready;
    hpdcache_pkg::addr_t req_addr;
    // One-cycle pulse, no back-pressure
    logic                refill_valid;
    hpdcache_pkg::word_t refill_data;

    modport ctrl (output req_valid, req_addr, input req_ready, refill_valid, refill_data);
    modport miss (input req_valid, req_addr, output req_ready, refill_valid, refill_data);
endinterface

interface hpdcache_wbuf_if;
    logic                valid;
    logic                ready;
    hpdcache_pkg::addr_t addr;
    hpdcache_pkg::word_t data;

    modport ctrl (output valid, addr, data, input ready);
    modport wbuf (input valid, addr, data, output ready);
endinterface

`default_nettype wire

// File: logic/hpdcache_req_arbiter.sv
/*
 * Fixed-priority arbiter, requester 0 wins. Purely combinational.
 * A requester losing the grant keeps its request pending.
 */
`timescale 1ns/1ns
`default_nettype none
`include "hpdcache_defs.svh"

module hpdcache_req_arbiter (
    input  logic [`HPDCACHE_NREQ-1:0] core_req_valid_i,
    input  logic                      core_req_we_i    [`HPDCACHE_NREQ-1:0],
    input  hpdcache_pkg::addr_t       core_req_addr_i  [`HPDCACHE_NREQ-1:0],
    input  hpdcache_pkg::word_t       core_req_wdata_i [`HPDCACHE_NREQ-1:0],
    output logic                      core_req_ready_o [`HPDCACHE_NREQ-1:0],
    hpdcache_req_if.arbiter           req
);
    logic [`HPDCACHE_NREQ-1:0] gnt;
    logic                      found;

    always_comb begin
        gnt       = '0;
        found     = 1'b0;
        req.we    = 1'b0;
        req.addr  = '0;
        req.wdata = '0;
        req.sid   = '0;
        // Lowest index takes the grant
        for (int i = 0; i < `HPDCACHE_NREQ; i++) begin
            if (core_req_valid_i[i] && !found) begin
                found     = 1'b1;
                gnt[i]    = 1'b1;
                req.we    = core_req_we_i[i];
                req.addr  = core_req_addr_i[i];
                req.wdata = core_req_wdata_i[i];
                req.sid   = hpdcache_pkg::sid_t'(i);
            end
        end
        req.valid = found;
    end

    for (genvar g = 0; g < `HPDCACHE_NREQ; g++) begin : gen_ready
        assign core_req_ready_o[g] = gnt[g] & req.ready;
    end

endmodule

`default_nettype wire

// File: logic/hpdcache_ctrl.sv
/*
 * Direct-mapped, write-through, no-write-allocate controller.
 * One read miss in flight; reads wait for the write buffer to drain first.
 * With cfg_enable_i low every read goes to memory and nothing is filled.
 */
`timescale 1ns/1ns
`default_nettype none
`include "hpdcache_defs.svh"

module hpdcache_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                cfg_enable_i,
    hpdcache_req_if.ctrl        req,
    hpdcache_miss_if.ctrl       miss,
    hpdcache_wbuf_if.ctrl       wbuf,
    input  logic                wbuf_empty_i,
    output logic                rsp_valid_o,
    output hpdcache_pkg::sid_t  rsp_sid_o,
    output hpdcache_pkg::word_t rsp_rdata_o
);
    typedef enum logic [1:0] {ST_IDLE, ST_DRAIN, ST_REQ, ST_WAIT} state_e;

    state_e                    st_q;
    logic [`HPDCACHE_SETS-1:0] valid_q;
    hpdcache_pkg::tag_t        tag_q  [`HPDCACHE_SETS];
    hpdcache_pkg::word_t       data_q [`HPDCACHE_SETS];
    hpdcache_pkg::addr_t       miss_addr_q;
    hpdcache_pkg::sid_t        miss_sid_q;
    hpdcache_pkg::set_t        req_set;
    hpdcache_pkg::tag_t        req_tag;
    hpdcache_pkg::set_t        miss_set;
    hpdcache_pkg::tag_t        miss_tag;
    logic                      accept;
    logic                      hit;
    logic                      read_hit;
    logic                      read_miss;
    logic                      refill;
    logic                      fill;

    assign req_set  = hpdcache_pkg::set_t'(req.addr);
    assign req_tag  = hpdcache_pkg::tag_t'(req.addr >> $bits(hpdcache_pkg::set_t));
    assign miss_set = hpdcache_pkg::set_t'(miss_addr_q);
    assign miss_tag = hpdcache_pkg::tag_t'(miss_addr_q >> $bits(hpdcache_pkg::set_t));

    assign hit       = valid_q[req_set] && (tag_q[req_set] == req_tag);
    assign req.ready = (st_q == ST_IDLE) && (!req.we || wbuf.ready);
    assign accept    = req.valid && req.ready;
    assign read_hit  = accept && !req.we && hit && cfg_enable_i;
    assign read_miss = accept && !req.we && !read_hit;

    // Every write goes through the buffer, hit or not
    assign wbuf.valid = req.valid && req.we && (st_q == ST_IDLE);
    assign wbuf.addr  = req.addr;
    assign wbuf.data  = req.wdata;

    assign miss.req_valid = (st_q == ST_REQ);
    assign miss.req_addr  = miss_addr_q;

    assign refill = (st_q == ST_WAIT) && miss.refill_valid;
    assign fill   = refill && cfg_enable_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st_q        <= ST_IDLE;
            valid_q     <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= read_hit || refill;
            case (st_q)
                ST_IDLE: begin
                    if (read_miss) begin
                        st_q <= ST_DRAIN;
                    end
                end
                // Older writes must reach memory before the read
                ST_DRAIN: begin
                    if (wbuf_empty_i) begin
                        st_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (miss.req_ready) begin
                        st_q <= ST_WAIT;
                    end
                end
                default: begin
                    if (refill) begin
                        st_q <= ST_IDLE;
                    end
                end
            endcase
            if (fill) begin
                valid_q[miss_set] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && req.we && hit) begin
            data_q[req_set] <= req.wdata;
        end
        if (read_hit) begin
            rsp_rdata_o <= data_q[req_set];
            rsp_sid_o   <= req.sid;
        end
        if (read_miss) begin
            miss_addr_q <= req.addr;
            miss_sid_q  <= req.sid;
        end
        if (fill) begin
            tag_q[miss_set]  <= miss_tag;
            data_q[miss_set] <= miss.refill_data;
        end
        if (refill) begin
            rsp_rdata_o <= miss.refill_data;
            rsp_sid_o   <= miss_sid_q;
        end
    end

endmodule

`default_nettype wire

// File: logic/hpdcache_miss_handler.sv
/*
 * Single-entry miss handler. Takes no new miss until the response is back.
 * The memory read response must come as a one-cycle pulse.
 */
`timescale 1ns/1ns
`default_nettype none

module hpdcache_miss_handler (
    input  logic                clk_i,
    input  logic                rst_n_i,
    hpdcache_miss_if.miss       miss,
    output logic                mem_req_read_valid_o,
    input  logic                mem_req_read_ready_i,
    output hpdcache_pkg::addr_t mem_req_read_addr_o,
    input  logic                mem_resp_read_valid_i,
    input  hpdcache_pkg::word_t mem_resp_read_data_i
);
    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_BUSY} state_e;

    state_e              st_q;
    hpdcache_pkg::addr_t addr_q;
    logic                refill_valid_q;
    hpdcache_pkg::word_t refill_data_q;

    assign miss.req_ready       = (st_q == ST_IDLE);
    assign mem_req_read_valid_o = (st_q == ST_REQ);
    assign mem_req_read_addr_o  = addr_q;
    assign miss.refill_valid    = refill_valid_q;
    assign miss.refill_data     = refill_data_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st_q           <= ST_IDLE;
            refill_valid_q <= 1'b0;
        end else begin
            refill_valid_q <= 1'b0;
            case (st_q)
                ST_IDLE: begin
                    if (miss.req_valid) begin
                        st_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_req_read_ready_i) begin
                        st_q <= ST_BUSY;
                    end
                end
                default: begin
                    if (mem_resp_read_valid_i) begin
                        refill_valid_q <= 1'b1;
                        st_q           <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss.req_valid && miss.req_ready) begin
            addr_q <= miss.req_addr;
        end
        if (st_q == ST_BUSY && mem_resp_read_valid_i) begin
            refill_data_q <= mem_resp_read_data_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/hpdcache_wbuf.sv
/*
 * In-order write FIFO, no coalescing. The head entry is always offered
 * to memory, so the buffer drains whenever write ready is high.
 */
`timescale 1ns/1ns
`default_nettype none
`include "hpdcache_defs.svh"

module hpdcache_wbuf (
    input  logic                clk_i,
    input  logic                rst_n_i,
    hpdcache_wbuf_if.wbuf       wbuf,
    output logic                empty_o,
    output logic                mem_req_write_valid_o,
    input  logic                mem_req_write_ready_i,
    output hpdcache_pkg::addr_t mem_req_write_addr_o,
    output hpdcache_pkg::word_t mem_req_write_data_o
);
    localparam int DEPTH = `HPDCACHE_WBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    hpdcache_pkg::addr_t addr_mem [DEPTH];
    hpdcache_pkg::word_t data_mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic                push;
    logic                pop;

    assign wbuf.ready            = (count_q != CNT_W'(DEPTH));
    assign empty_o               = (count_q == '0);
    assign mem_req_write_valid_o = !empty_o;
    assign mem_req_write_addr_o  = addr_mem[rd_ptr_q];
    assign mem_req_write_data_o  = data_mem[rd_ptr_q];
    assign push                  = wbuf.valid && wbuf.ready;
    assign pop                   = mem_req_write_valid_o && mem_req_write_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_mem[wr_ptr_q] <= wbuf.addr;
            data_mem[wr_ptr_q] <= wbuf.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/hpdcache.sv
/*
 * Cache top. Read data is shared by all requesters; only the valid
 * of the requester that issued the read is raised. Writes get no response.
 */
`timescale 1ns/1ns
`default_nettype none
`include "hpdcache_defs.svh"

module hpdcache (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      cfg_enable_i,

    input  logic [`HPDCACHE_NREQ-1:0] core_req_valid_i,
    input  logic                      core_req_we_i    [`HPDCACHE_NREQ-1:0],
    input  hpdcache_pkg::addr_t       core_req_addr_i  [`HPDCACHE_NREQ-1:0],
    input  hpdcache_pkg::word_t       core_req_wdata_i [`HPDCACHE_NREQ-1:0],
    output logic                      core_req_ready_o [`HPDCACHE_NREQ-1:0],
    output logic [`HPDCACHE_NREQ-1:0] core_rsp_valid_o,
    output hpdcache_pkg::word_t       core_rsp_rdata_o,

    output logic                      mem_req_read_valid_o,
    input  logic                      mem_req_read_ready_i,
    output hpdcache_pkg::addr_t       mem_req_read_addr_o,
    input  logic                      mem_resp_read_valid_i,
    input  hpdcache_pkg::word_t       mem_resp_read_data_i,

    output logic                      mem_req_write_valid_o,
    input  logic                      mem_req_write_ready_i,
    output hpdcache_pkg::addr_t       mem_req_write_addr_o,
    output hpdcache_pkg::word_t       mem_req_write_data_o,
    output logic                      wbuf_empty_o
);
    logic               rsp_valid;
    hpdcache_pkg::sid_t rsp_sid;

    hpdcache_req_if  req_if ();
    hpdcache_miss_if miss_if ();
    hpdcache_wbuf_if wbuf_if ();

    hpdcache_req_arbiter i_req_arbiter (
        .core_req_valid_i (core_req_valid_i),
        .core_req_we_i    (core_req_we_i),
        .core_req_addr_i  (core_req_addr_i),
        .core_req_wdata_i (core_req_wdata_i),
        .core_req_ready_o (core_req_ready_o),
        .req              (req_if.arbiter)
    );

    hpdcache_ctrl i_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cfg_enable_i (cfg_enable_i),
        .req          (req_if.ctrl),
        .miss         (miss_if.ctrl),
        .wbuf         (wbuf_if.ctrl),
        .wbuf_empty_i (wbuf_empty_o),
        .rsp_valid_o  (rsp_valid),
        .rsp_sid_o    (rsp_sid),
        .rsp_rdata_o  (core_rsp_rdata_o)
    );

    hpdcache_miss_handler i_miss_handler (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .miss                  (miss_if.miss),
        .mem_req_read_valid_o  (mem_req_read_valid_o),
        .mem_req_read_ready_i  (mem_req_read_ready_i),
        .mem_req_read_addr_o   (mem_req_read_addr_o),
        .mem_resp_read_valid_i (mem_resp_read_valid_i),
        .mem_resp_read_data_i  (mem_resp_read_data_i)
    );

    hpdcache_wbuf i_wbuf (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .wbuf                  (wbuf_if.wbuf),
        .empty_o               (wbuf_empty_o),
        .mem_req_write_valid_o (mem_req_write_valid_o),
        .mem_req_write_ready_i (mem_req_write_ready_i),
        .mem_req_write_addr_o  (mem_req_write_addr_o),
        .mem_req_write_data_o  (mem_req_write_data_o)
    );

    // Route the response valid back by source id
    always_comb begin
        for (int i = 0; i < `HPDCACHE_NREQ; i++) begin
            core_rsp_valid_o[i] = rsp_valid && (rsp_sid == hpdcache_pkg::sid_t'(i));
        end
    end

endmodule

`default_nettype wire

// File: test/hpdcache_tb.sv
/*
 * Testbench for the cache top. Memory keeps read ready high and answers
 * reads after 1 to 6 cycles. DUT outputs are sampled on the falling edge.
 */
`timescale 1ns/1ns
`default_nettype none
`include "hpdcache_defs.svh"

module hpdcache_tb;
    localparam int NREQ    = `HPDCACHE_NREQ;
    localparam int TIMEOUT = 200;

    typedef struct {
        string               name;
        bit                  en;
        int                  req;
        bit                  we;
        hpdcache_pkg::addr_t addr;
        hpdcache_pkg::word_t wdata;
        bit                  hold;
        hpdcache_pkg::word_t exp;
        int                  rd_delta;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                cfg_enable;
    logic [NREQ-1:0]     req_valid;
    logic                req_we    [NREQ-1:0];
    hpdcache_pkg::addr_t req_addr  [NREQ-1:0];
    hpdcache_pkg::word_t req_wdata [NREQ-1:0];
    logic                req_ready [NREQ-1:0];
    logic [NREQ-1:0]     rsp_valid;
    hpdcache_pkg::word_t rsp_rdata;
    logic                rd_valid;
    logic                rd_ready;
    hpdcache_pkg::addr_t rd_addr;
    logic                rd_resp_valid;
    hpdcache_pkg::word_t rd_resp_data;
    logic                wr_valid;
    logic                wr_ready;
    hpdcache_pkg::addr_t wr_addr;
    hpdcache_pkg::word_t wr_data;
    logic                wbuf_empty;

    hpdcache_pkg::word_t mem [2**`HPDCACHE_ADDR_W];
    hpdcache_pkg::addr_t wr_log_addr [$];
    hpdcache_pkg::word_t wr_log_data [$];
    row_t                rows [$];
    int unsigned         lcg_state = 68552;
    int                  rd_count  = 0;
    int                  cyc       = 0;
    int                  checks    = 0;
    int                  errors    = 0;
    bit                  hung      = 1'b0;

    hpdcache i_hpdcache (
        .clk_i                 (clk),
        .rst_n_i               (rst_n),
        .cfg_enable_i          (cfg_enable),
        .core_req_valid_i      (req_valid),
        .core_req_we_i         (req_we),
        .core_req_addr_i       (req_addr),
        .core_req_wdata_i      (req_wdata),
        .core_req_ready_o      (req_ready),
        .core_rsp_valid_o      (rsp_valid),
        .core_rsp_rdata_o      (rsp_rdata),
        .mem_req_read_valid_o  (rd_valid),
        .mem_req_read_ready_i  (rd_ready),
        .mem_req_read_addr_o   (rd_addr),
        .mem_resp_read_valid_i (rd_resp_valid),
        .mem_resp_read_data_i  (rd_resp_data),
        .mem_req_write_valid_o (wr_valid),
        .mem_req_write_ready_i (wr_ready),
        .mem_req_write_addr_o  (wr_addr),
        .mem_req_write_data_o  (wr_data),
        .wbuf_empty_o          (wbuf_empty)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Initial memory contents, unique per word address
    function automatic hpdcache_pkg::word_t mem_pattern(input hpdcache_pkg::addr_t a);
        return {~a, a};
    endfunction

    function automatic hpdcache_pkg::sid_t rsp_owner(input logic [NREQ-1:0] v);
        hpdcache_pkg::sid_t s;
        s = '0;
        for (int i = NREQ - 1; i >= 0; i--) begin
            if (v[i]) begin
                s = hpdcache_pkg::sid_t'(i);
            end
        end
        return s;
    endfunction

    // Read side of the memory model
    initial begin : read_memory
        hpdcache_pkg::addr_t a;
        int unsigned         delay;
        rd_resp_valid = 1'b0;
        rd_resp_data  = '0;
        forever begin
            @(negedge clk);
            if (rd_valid && rd_ready) begin
                a = rd_addr;
                rd_count++;
                delay = 1 + lcg_next() % 6;
                repeat (delay) @(posedge clk);
                #1;
                rd_resp_valid = 1'b1;
                rd_resp_data  = mem[a];
                @(posedge clk);
                #1;
                rd_resp_valid = 1'b0;
            end
        end
    end

    // Write side, also owns the memory array
    initial begin : write_memory
        for (int i = 0; i < 2**`HPDCACHE_ADDR_W; i++) begin
            mem[i] = mem_pattern(hpdcache_pkg::addr_t'(i));
        end
        forever begin
            @(negedge clk);
            if (wr_valid && wr_ready) begin
                mem[wr_addr] = wr_data;
                wr_log_addr.push_back(wr_addr);
                wr_log_data.push_back(wr_data);
            end
        end
    end

    task automatic end_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin : timeout_exit
        wait (hung);
        end_run();
    end

    task automatic check_word(input string name, input hpdcache_pkg::word_t exp,
                              input hpdcache_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_sid(input string name, input hpdcache_pkg::sid_t exp,
                             input hpdcache_pkg::sid_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic drive_req(input int r, input bit we, input hpdcache_pkg::addr_t a,
                             input hpdcache_pkg::word_t d);
        @(posedge clk);
        #1;
        req_valid[r] = 1'b1;
        req_we[r]    = we;
        req_addr[r]  = a;
        req_wdata[r] = d;
        @(negedge clk);
    endtask

    task automatic release_req(input int r);
        @(posedge clk);
        #1;
        req_valid[r] = 1'b0;
        @(negedge clk);
    endtask

    // All waits are entered on a falling edge and look at the current state first
    task automatic await_accept(input int r);
        int n;
        n = 0;
        while (!req_ready[r]) begin
            if (n == TIMEOUT) begin
                errors++;
                $display("Timed out waiting for requester %0d to be accepted", r);
                hung = 1'b1;
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic await_rsp(input string name, input int r, input hpdcache_pkg::word_t exp);
        int n;
        n = 0;
        while (rsp_valid == '0) begin
            if (n == TIMEOUT) begin
                errors++;
                $display("Timed out waiting for the response of %s", name);
                hung = 1'b1;
            end
            @(negedge clk);
            n++;
        end
        check_count({name, " valid count"}, 1, $countones(rsp_valid));
        check_sid({name, " owner"}, hpdcache_pkg::sid_t'(r), rsp_owner(rsp_valid));
        check_word({name, " data"}, exp, rsp_rdata);
    endtask

    task automatic await_empty(input string name);
        int n;
        n = 0;
        while (!wbuf_empty) begin
            if (n == TIMEOUT) begin
                errors++;
                $display("Timed out waiting for the write buffer to drain after %s", name);
                hung = 1'b1;
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic add_row(input string name, input bit en, input int r, input bit we,
                           input hpdcache_pkg::addr_t a, input hpdcache_pkg::word_t d,
                           input bit hold, input hpdcache_pkg::word_t exp, input int delta);
        row_t row;
        row = '{name, en, r, we, a, d, hold, exp, delta};
        rows.push_back(row);
    endtask

    task automatic build_table();
        add_row("first read", 1, 0, 0, 16'h0012, '0, 0, mem_pattern(16'h0012), 1);
        add_row("repeat read", 1, 0, 0, 16'h0012, '0, 0, mem_pattern(16'h0012), 0);
        add_row("write hit", 1, 1, 1, 16'h0012, 32'hcafe0012, 0, '0, 0);
        add_row("read after write", 1, 1, 0, 16'h0012, '0, 0, 32'hcafe0012, 0);
        add_row("write miss", 1, 0, 1, 16'h0345, 32'h12345678, 1, '0, 0);
        add_row("read unallocated", 1, 0, 0, 16'h0345, '0, 1, 32'h12345678, 1);
        add_row("read refilled", 1, 1, 0, 16'h0345, '0, 0, 32'h12345678, 0);
        add_row("disabled read a", 0, 0, 0, 16'h0012, '0, 0, 32'hcafe0012, 1);
        add_row("disabled read b", 0, 1, 0, 16'h0012, '0, 0, 32'hcafe0012, 1);
        for (int i = 0; i < 4; i++) begin
            add_row("held write", 1, 0, 1, hpdcache_pkg::addr_t'(16'h0100 + i),
                    32'hb0000100 + i, 1, '0, 0);
        end
    endtask

    task automatic apply_row(input row_t row);
        int rd_before;
        int acc_cyc;
        rd_before = rd_count;
        @(posedge clk);
        #1;
        cfg_enable = row.en;
        wr_ready   = !row.hold;
        drive_req(row.req, row.we, row.addr, row.wdata);
        await_accept(row.req);
        acc_cyc = cyc;
        release_req(row.req);
        if (!row.we) begin
            // The buffered write is still held, so the miss must not reach memory
            if (row.hold) begin
                repeat (10) @(negedge clk);
                check_count({row.name, " reads while held"}, 0, rd_count - rd_before);
                @(posedge clk);
                #1;
                wr_ready = 1'b1;
            end
            await_rsp(row.name, row.req, row.exp);
            if (row.rd_delta == 0) begin
                check_count({row.name, " latency"}, 1, cyc - acc_cyc);
            end
            check_count({row.name, " memory reads"}, row.rd_delta, rd_count - rd_before);
        end else if (!row.hold) begin
            await_empty(row.name);
            check_word({row.name, " write addr"}, hpdcache_pkg::word_t'(row.addr),
                       hpdcache_pkg::word_t'(wr_log_addr[$]));
            check_word({row.name, " write data"}, row.wdata, wr_log_data[$]);
        end
    endtask

    // Buffer is full from the held rows; the fifth write must wait
    task automatic stall_test();
        int seen;
        int base;
        seen = 0;
        drive_req(0, 1'b1, 16'h0104, 32'hb0000104);
        repeat (20) begin
            if (req_ready[0]) begin
                seen++;
            end
            @(negedge clk);
        end
        check_count("fifth write stall", 0, seen);
        @(posedge clk);
        #1;
        wr_ready = 1'b1;
        @(negedge clk);
        await_accept(0);
        release_req(0);
        await_empty("fifth write");
        base = wr_log_addr.size() - 5;
        for (int i = 0; i < 5; i++) begin
            check_word("drain order addr", 32'h0100 + i,
                       hpdcache_pkg::word_t'(wr_log_addr[base + i]));
            check_word("drain order data", 32'hb0000100 + i, wr_log_data[base + i]);
        end
    endtask

    task automatic arbitration_test();
        @(posedge clk);
        #1;
        req_valid   = '1;
        req_we[0]   = 1'b0;
        req_we[1]   = 1'b0;
        req_addr[0] = 16'h0345;
        req_addr[1] = 16'h0012;
        @(negedge clk);
        await_accept(0);
        check_count("low priority held", 0, int'(req_ready[1]));
        release_req(0);
        await_rsp("arbitration req0", 0, 32'h12345678);
        await_accept(1);
        release_req(1);
        await_rsp("arbitration req1", 1, 32'hcafe0012);
    endtask

    initial begin : main
        rst_n      = 1'b0;
        cfg_enable = 1'b1;
        req_valid  = '0;
        rd_ready   = 1'b1;
        wr_ready   = 1'b1;
        for (int i = 0; i < NREQ; i++) begin
            req_we[i]    = 1'b0;
            req_addr[i]  = '0;
            req_wdata[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_count("outputs after reset", 0,
                    int'(rsp_valid) + int'(rd_valid) + int'(wr_valid));
        build_table();
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        stall_test();
        arbitration_test();
        end_run();
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/hpdcache_pkg.sv
logic/hpdcache_ifs.sv
logic/hpdcache_req_arbiter.sv
logic/hpdcache_ctrl.sv
logic/hpdcache_miss_handler.sv
logic/hpdcache_wbuf.sv
logic/hpdcache.sv
test/hpdcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module hpdcache_tb -f files.f -o hpdcache_sim
out="$(./obj_dir/hpdcache_sim)"
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
